/* design/sqrt_alg_pkg.sv */
package sqrt_alg_pkg;

    // Recurrence datapath widths
    localparam int RES_W      = 28;  // Sign, integer guard, root bits, ILSB alignment
    localparam int EST_W      = 4;   // Estimate width, half-unit resolution
    localparam int ITER_COUNT = 24;  // Root digits, first one fixed at load

    // Bit of weight 1 in radicand units, 1/2 in root units
    localparam int ONE_POS = 24;

    typedef logic [RES_W-1:0] rad_t;    // Radicand, LSB weight 2^-24
    typedef logic [RES_W-1:0] resid_t;  // Residual and root words, LSB weight 2^-25
    typedef logic [4:0]       iter_t;   // Step index 0..ITER_COUNT-1

    // Signed root digit
    typedef enum logic [1:0] {
        DIGIT_ZERO = 2'b00,
        DIGIT_POS  = 2'b01,
        DIGIT_NEG  = 2'b11
    } root_digit_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_NEG  = 2'b01,  // Negative operand short path
        ST_ITER = 2'b10,  // Load cycle plus recurrence steps
        ST_DONE = 2'b11
    } sqrt_state_e;

    // Redundant residual, value is sum + carry
    typedef struct packed {
        resid_t sum;
        resid_t carry;
    } csa_resid_t;

    // Root forms as addends for the next step
    typedef struct packed {
        resid_t root;     // 2q plus tail 01
        resid_t root_m1;  // 2(q - ulp) plus tail 11
    } root_pair_t;

endpackage

/* design/sqrt_fmt_pkg.sv */
package sqrt_fmt_pkg;

    // Single precision word layout
    localparam int FRAC_W   = 23;
    localparam int EXP_W    = 8;
    localparam int WORD_W   = 32;
    localparam int EXP_BIAS = 127;

    typedef logic [WORD_W-1:0] float_word_t;
    typedef logic [EXP_W-1:0]  exp_t;
    typedef logic [FRAC_W-1:0] frac_t;

    // Result for a negative operand
    localparam float_word_t ALL_ONES_RESULT = '1;

    // Operand after field split and alignment
    typedef struct packed {
        logic               neg;       // Sign of operand
        exp_t               res_exp;   // Halved biased exponent
        sqrt_alg_pkg::rad_t radicand;  // s or 2s by parity
    } unpacked_op_t;

endpackage

/* design/sqrt_unpack.sv */
`timescale 1ns/1ps

module sqrt_unpack (
    input  sqrt_fmt_pkg::float_word_t  x,
    output sqrt_fmt_pkg::unpacked_op_t op
);

    sqrt_fmt_pkg::exp_t  exp_in;
    sqrt_fmt_pkg::frac_t frac_in;
    logic [sqrt_fmt_pkg::FRAC_W+1:0] sig;      // 1.m plus ILSB, 25 bits
    logic signed [sqrt_fmt_pkg::EXP_W:0] u;    // Unbiased exponent
    logic signed [sqrt_fmt_pkg::EXP_W:0] u_half;
    logic signed [sqrt_fmt_pkg::EXP_W:0] e_out;
    logic u_odd;

    assign exp_in  = x[sqrt_fmt_pkg::WORD_W-2 -: sqrt_fmt_pkg::EXP_W];
    assign frac_in = x[sqrt_fmt_pkg::FRAC_W-1:0];

    // HUB significand, implicit one on both ends
    assign sig = {1'b1, frac_in, 1'b1};

    // Bias is odd, so u is odd when the stored exponent is even
    assign u_odd = ~exp_in[0];

    assign u      = $signed({1'b0, exp_in}) - (sqrt_fmt_pkg::EXP_W+1)'(sqrt_fmt_pkg::EXP_BIAS);
    assign u_half = u >>> 1;  // Floor division by two
    assign e_out  = u_half + (sqrt_fmt_pkg::EXP_W+1)'(sqrt_fmt_pkg::EXP_BIAS);

    always_comb begin
        op.neg     = x[sqrt_fmt_pkg::WORD_W-1];
        op.res_exp = e_out[sqrt_fmt_pkg::EXP_W-1:0];
        if (u_odd) begin
            op.radicand = sqrt_alg_pkg::rad_t'({sig, 1'b0});  // 2s, range [2,4)
        end else begin
            op.radicand = sqrt_alg_pkg::rad_t'(sig);          // s, range [1,2)
        end
    end

endmodule

/* design/sqrt_residual.sv */
`timescale 1ns/1ps

module sqrt_residual (
    input  logic                        clk,
    input  logic                        rst_l,
    input  logic                        load,
    input  logic                        step,
    input  sqrt_fmt_pkg::unpacked_op_t  op,
    input  sqrt_alg_pkg::root_pair_t    roots,
    output sqrt_alg_pkg::root_digit_e   digit,
    output logic                        resid_neg
);

    sqrt_alg_pkg::csa_resid_t w;        // Residual registers
    sqrt_alg_pkg::csa_resid_t w_next;
    sqrt_alg_pkg::resid_t     a, b, c;  // 3:2 inputs
    sqrt_alg_pkg::resid_t     w_full;
    logic                     cin;      // Two's complement +1 for subtraction
    logic [sqrt_alg_pkg::EST_W-1:0] est;

    // Doubled residual, both words
    assign a = w.sum << 1;
    assign b = w.carry << 1;

    // Estimate of 2w from top bits, steps of 1/2 in [-4,4)
    assign est = w.sum[sqrt_alg_pkg::RES_W-2 -: sqrt_alg_pkg::EST_W]
               + w.carry[sqrt_alg_pkg::RES_W-2 -: sqrt_alg_pkg::EST_W];

    always_comb begin
        if (est == '1) begin
            digit = sqrt_alg_pkg::DIGIT_ZERO;  // Estimate -1/2
        end else if (!est[sqrt_alg_pkg::EST_W-1]) begin
            digit = sqrt_alg_pkg::DIGIT_POS;
        end else begin
            digit = sqrt_alg_pkg::DIGIT_NEG;
        end
    end

    // Addend by digit
    always_comb begin
        unique case (digit)
            sqrt_alg_pkg::DIGIT_POS: begin
                c   = ~roots.root;  // Subtract 2q + 2^-(j+1)
                cin = 1'b1;
            end
            sqrt_alg_pkg::DIGIT_NEG: begin
                c   = roots.root_m1;  // Add 2q - 2^-(j+1)
                cin = 1'b0;
            end
            default: begin
                c   = '0;
                cin = 1'b0;
            end
        endcase
    end

    // Carry-save add, no carry ripple
    assign w_next.sum   = a ^ b ^ c;
    assign w_next.carry = (((a & b) | (a & c) | (b & c)) << 1) | sqrt_alg_pkg::resid_t'(cin);

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            w <= '0;
        end else if (load) begin
            // w[1] = (X - 1) / 2 after the fixed first digit
            w.sum   <= op.radicand - (sqrt_alg_pkg::resid_t'(1) << sqrt_alg_pkg::ONE_POS);
            w.carry <= '0;
        end else if (step) begin
            w <= w_next;
        end
    end

    // Sign of final residual needs the full sum
    assign w_full    = w.sum + w.carry;
    assign resid_neg = w_full[sqrt_alg_pkg::RES_W-1];

endmodule

/* design/sqrt_root_conv.sv */
`timescale 1ns/1ps

module sqrt_root_conv (
    input  logic                       clk,
    input  logic                       rst_l,
    input  logic                       load,
    input  logic                       step,
    input  sqrt_alg_pkg::iter_t        iter,
    input  sqrt_alg_pkg::root_digit_e  digit,
    input  logic                       resid_neg,
    output sqrt_alg_pkg::root_pair_t   roots,
    output sqrt_fmt_pkg::frac_t        frac
);

    sqrt_alg_pkg::resid_t q;    // Partial root, LSB 2^-25, 1/2 at ONE_POS
    sqrt_alg_pkg::resid_t qm;   // Partial root minus one ulp
    sqrt_alg_pkg::resid_t dbit; // Weight of the digit being formed
    sqrt_alg_pkg::resid_t sel;

    // Step j puts digit weight 2^-(j+1) at bit ONE_POS - j
    assign dbit = sqrt_alg_pkg::resid_t'(1) << (sqrt_alg_pkg::ONE_POS - int'(iter));

    // Addends with tail bits appended, no carry needed
    assign roots.root    = (q << 1) | dbit;
    assign roots.root_m1 = (qm << 1) | (dbit << 1) | dbit;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            q  <= '0;
            qm <= '0;
        end else if (load) begin
            q  <= sqrt_alg_pkg::resid_t'(1) << sqrt_alg_pkg::ONE_POS;  // First digit is 1
            qm <= '0;
        end else if (step) begin
            unique case (digit)
                sqrt_alg_pkg::DIGIT_POS: begin
                    q  <= q | dbit;
                    qm <= q;
                end
                sqrt_alg_pkg::DIGIT_NEG: begin
                    q  <= qm | dbit;
                    qm <= qm;
                end
                default: begin
                    q  <= q;
                    qm <= qm | dbit;
                end
            endcase
        end
    end

    // Negative remainder means root overshoots by one ulp
    assign sel = resid_neg ? qm : q;

    // Drop the leading one, keep 23 bits below it
    assign frac = sel[sqrt_alg_pkg::ONE_POS-1 -: sqrt_fmt_pkg::FRAC_W];

endmodule

/* design/sqrt_control.sv */
`timescale 1ns/1ps

module sqrt_control (
    input  logic                        clk,
    input  logic                        rst_l,
    input  logic                        start,
    input  sqrt_fmt_pkg::unpacked_op_t  op,
    input  sqrt_fmt_pkg::frac_t         frac,
    output logic                        load,
    output logic                        step,
    output sqrt_alg_pkg::iter_t         iter,
    output sqrt_fmt_pkg::float_word_t   res,
    output logic                        finish,
    output logic                        busy
);

    sqrt_alg_pkg::sqrt_state_e state;
    sqrt_fmt_pkg::exp_t        res_exp;  // Captured at accept

    localparam sqrt_alg_pkg::iter_t LAST_ITER = sqrt_alg_pkg::iter_t'(sqrt_alg_pkg::ITER_COUNT - 1);

    // First ITER cycle loads, the rest step
    assign load = (state == sqrt_alg_pkg::ST_ITER) && (iter == '0);
    assign step = (state == sqrt_alg_pkg::ST_ITER);

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state   <= sqrt_alg_pkg::ST_IDLE;
            iter    <= '0;
            res_exp <= '0;
            res     <= '0;
            finish  <= 1'b0;
            busy    <= 1'b0;
        end else begin
            // Result only lives for one cycle
            finish <= 1'b0;
            res    <= '0;
            unique case (state)
                sqrt_alg_pkg::ST_IDLE: begin
                    if (start) begin
                        res_exp <= op.res_exp;
                        iter    <= '0;
                        busy    <= 1'b1;
                        if (op.neg) begin
                            state <= sqrt_alg_pkg::ST_NEG;
                        end else begin
                            state <= sqrt_alg_pkg::ST_ITER;
                        end
                    end
                end
                sqrt_alg_pkg::ST_NEG: begin
                    res    <= sqrt_fmt_pkg::ALL_ONES_RESULT;
                    finish <= 1'b1;
                    busy   <= 1'b0;
                    state  <= sqrt_alg_pkg::ST_IDLE;
                end
                sqrt_alg_pkg::ST_ITER: begin
                    if (iter == LAST_ITER) begin
                        state <= sqrt_alg_pkg::ST_DONE;  // All digits formed
                    end else begin
                        iter <= iter + 1'b1;
                    end
                end
                sqrt_alg_pkg::ST_DONE: begin
                    res    <= {1'b0, res_exp, frac};  // Sign always positive
                    finish <= 1'b1;
                    busy   <= 1'b0;
                    state  <= sqrt_alg_pkg::ST_IDLE;
                end
                default: begin
                    state <= sqrt_alg_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/fp_sqrt_top.sv */
`timescale 1ns/1ps

module fp_sqrt_top (
    input  logic                       clk,
    input  logic                       rst_l,
    input  logic                       start,
    input  sqrt_fmt_pkg::float_word_t  x,
    output sqrt_fmt_pkg::float_word_t  res,
    output logic                       finish,
    output logic                       busy
);

    sqrt_fmt_pkg::unpacked_op_t op;
    sqrt_fmt_pkg::frac_t        frac;
    sqrt_alg_pkg::iter_t        iter;
    sqrt_alg_pkg::root_digit_e  digit;
    sqrt_alg_pkg::root_pair_t   roots;
    logic                       load;
    logic                       step;
    logic                       resid_neg;

    // Field split, combinational
    sqrt_unpack sqrt_unpack_inst (
        .x  (x),
        .op (op)
    );

    sqrt_control sqrt_control_inst (
        .clk    (clk),
        .rst_l  (rst_l),
        .start  (start),
        .op     (op),
        .frac   (frac),
        .load   (load),
        .step   (step),
        .iter   (iter),
        .res    (res),
        .finish (finish),
        .busy   (busy)
    );

    // Residual and digit selection
    sqrt_residual sqrt_residual_inst (
        .clk       (clk),
        .rst_l     (rst_l),
        .load      (load),
        .step      (step),
        .op        (op),
        .roots     (roots),
        .digit     (digit),
        .resid_neg (resid_neg)
    );

    // On-the-fly root forms
    sqrt_root_conv sqrt_root_conv_inst (
        .clk       (clk),
        .rst_l     (rst_l),
        .load      (load),
        .step      (step),
        .iter      (iter),
        .digit     (digit),
        .resid_neg (resid_neg),
        .roots     (roots),
        .frac      (frac)
    );

endmodule

/* sim/fp_sqrt_props.sv */
`timescale 1ns/1ps

module fp_sqrt_props (
    input logic                      clk,
    input logic                      rst_l,
    input logic                      start,
    input sqrt_fmt_pkg::float_word_t x,
    input sqrt_fmt_pkg::float_word_t res,
    input logic                      finish,
    input logic                      busy
);

    // Completion strobe is a single cycle wide
    finish_one_cycle: assert property (@(posedge clk) disable iff (!rst_l)
        finish |=> !finish)
        else $error("finish stayed high for more than one cycle");

    finish_not_busy: assert property (@(posedge clk) disable iff (!rst_l)
        finish |-> !busy)  // Unit already idle when result shows
        else $error("busy high while finish is high");

    // Accepted positive operand, 24 digits plus load and done
    start_to_finish: assert property (@(posedge clk) disable iff (!rst_l)
        (start && !busy && !x[sqrt_fmt_pkg::WORD_W-1]) |-> ##26 finish)
        else $error("finish did not follow an accepted start by 26 cycles");

    // Result bus quiet outside the strobe
    res_zero_idle: assert property (@(posedge clk) disable iff (!rst_l)
        !finish |-> (res == '0))
        else $error("res not zero while finish is low");

endmodule

/* sim/fp_sqrt_tb.sv */
`timescale 1ns/1ps

module fp_sqrt_tb;

    localparam int CLK_HALF   = 10;
    localparam int DRIVE_DLY  = 2;   // Input skew after rising edge
    localparam int RESET_CYC  = 8;
    localparam int WAIT_LIMIT = 40;
    localparam int LAT_NORMAL = 26;  // Accept edge to finish edge
    localparam int LAT_NEG    = 2;
    localparam int BUSY_GAP   = 4;   // Cycles between accept and the stray start
    localparam int NUM_VEC    = 14;
    localparam int NUM_RANDOM = 40;

    typedef enum logic {
        CLS_NORMAL,
        CLS_NEG
    } op_class_e;

    // One table row
    typedef struct packed {
        sqrt_fmt_pkg::float_word_t operand;
        op_class_e                 cls;
        sqrt_fmt_pkg::float_word_t expected;  // Worked out by hand
    } vec_t;

    logic                      clk;
    logic                      rst_l;
    logic                      start;
    sqrt_fmt_pkg::float_word_t x;
    sqrt_fmt_pkg::float_word_t res;
    logic                      finish;
    logic                      busy;

    integer seed;
    int     mismatch_count;
    int     timeout_count;
    int     other_count;
    int     i;
    vec_t   vectors [NUM_VEC];
    sqrt_fmt_pkg::float_word_t ref_word;
    sqrt_fmt_pkg::float_word_t rnd_op;
    sqrt_fmt_pkg::exp_t        rnd_exp;
    sqrt_fmt_pkg::frac_t       rnd_frac;

    fp_sqrt_top fp_sqrt_top_inst (
        .clk    (clk),
        .rst_l  (rst_l),
        .start  (start),
        .x      (x),
        .res    (res),
        .finish (finish),
        .busy   (busy)
    );

    bind fp_sqrt_top fp_sqrt_props fp_sqrt_props_inst (
        .clk    (clk),
        .rst_l  (rst_l),
        .start  (start),
        .x      (x),
        .res    (res),
        .finish (finish),
        .busy   (busy)
    );

    always #CLK_HALF clk = ~clk;

    // Bitwise integer square root, floor
    function automatic logic [63:0] isqrt64(input logic [63:0] v);
        logic [63:0] r;
        logic [63:0] t;
        int          b;
        r = '0;
        for (b = 31; b >= 0; b--) begin
            t = r | (64'd1 << b);
            if (t * t <= v) begin
                r = t;
            end
        end
        return r;
    endfunction

    // Truncated HUB square root, straight from the format definition
    function automatic sqrt_fmt_pkg::float_word_t sqrt_ref(input sqrt_fmt_pkg::float_word_t op);
        int          e;
        int          u;
        int          uh;
        logic [63:0] sig;
        logic [63:0] rad;
        logic [63:0] root;
        if (op[31]) begin
            return 32'hFFFF_FFFF;
        end
        e   = int'(op[30:23]);
        u   = e - 127;
        uh  = u >>> 1;                            // Floor of u/2, also for negative u
        sig = {39'd0, 1'b1, op[22:0], 1'b1};      // s scaled by 2^24
        rad = (u & 1) ? (sig << 23) : (sig << 22); // Root lands in [2^23, 2^24)
        root = isqrt64(rad);
        return {1'b0, 8'(uh + 127), root[22:0]};
    endfunction

    task automatic load_table();
        // Even unbiased exponent
        vectors[0]  = '{32'h3F80_0000, CLS_NORMAL, 32'h3F80_0000};  // 1.0
        vectors[1]  = '{32'h4080_0000, CLS_NORMAL, 32'h4000_0000};  // 4.0
        vectors[2]  = '{32'h4180_0000, CLS_NORMAL, 32'h4080_0000};  // 16.0
        vectors[3]  = '{32'h4280_0000, CLS_NORMAL, 32'h4100_0000};  // 64.0
        vectors[4]  = '{32'h3E80_0000, CLS_NORMAL, 32'h3F00_0000};  // 0.25
        vectors[5]  = '{32'h3D80_0000, CLS_NORMAL, 32'h3E80_0000};  // 0.0625
        // Odd unbiased exponent, radicand doubled
        vectors[6]  = '{32'h4010_0000, CLS_NORMAL, 32'h3FC0_0000};  // 2.25
        vectors[7]  = '{32'h4110_0000, CLS_NORMAL, 32'h4040_0000};  // 9.0
        vectors[8]  = '{32'h4000_0000, CLS_NORMAL, 32'h3FB5_04F3};  // 2.0
        vectors[9]  = '{32'h4100_0000, CLS_NORMAL, 32'h4035_04F3};  // 8.0
        vectors[10] = '{32'h3F00_0000, CLS_NORMAL, 32'h3F35_04F3};  // 0.5
        // Negative short path
        vectors[11] = '{32'hBF80_0000, CLS_NEG, 32'hFFFF_FFFF};
        vectors[12] = '{32'hC080_0000, CLS_NEG, 32'hFFFF_FFFF};
        vectors[13] = '{32'hC000_0000, CLS_NEG, 32'hFFFF_FFFF};
    endtask

    // Called at edge plus skew, returns the same way
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end
        if (busy) begin
            $display("Timeout: DUT still busy after %0d cycles, start not possible", WAIT_LIMIT);
            timeout_count++;
        end
    endtask

    task automatic launch_op(input sqrt_fmt_pkg::float_word_t operand);
        wait_idle();
        x     = operand;  // Held until next launch, radicand loads a cycle late
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
    endtask

    // Finish seen after edge k+n is sampled high at edge k+n+1
    task automatic wait_finish(output int latency, output logic seen);
        int n;
        n = 0;
        while (!finish && n < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end
        seen    = finish;
        latency = n + 1;
    endtask

    task automatic run_op(input sqrt_fmt_pkg::float_word_t operand, input op_class_e cls,
                          input sqrt_fmt_pkg::float_word_t expected);
        int   lat;
        int   want_lat;
        logic seen;
        want_lat = (cls == CLS_NEG) ? LAT_NEG : LAT_NORMAL;
        launch_op(operand);
        if (busy !== 1'b1) begin
            $display("MISMATCH %0t: busy not raised after start, x=%h", $time, operand);
            mismatch_count++;
        end
        wait_finish(lat, seen);
        if (!seen) begin
            $display("Timeout: no finish within %0d cycles for operand %h", WAIT_LIMIT, operand);
            timeout_count++;
        end else begin
            if (lat != want_lat) begin
                $display("MISMATCH %0t: x=%h finish after %0d cycles, expected %0d",
                         $time, operand, lat, want_lat);
                mismatch_count++;
            end
            if (res !== expected) begin
                $display("MISMATCH %0t: x=%h res=%h expected %h",
                         $time, operand, res, expected);
                mismatch_count++;
            end
            if (busy !== 1'b0) begin
                $display("MISMATCH %0t: busy high with finish, x=%h", $time, operand);
                mismatch_count++;
            end
            @(posedge clk);
            #DRIVE_DLY;
            if (finish !== 1'b0 || res !== '0 || busy !== 1'b0) begin
                $display("MISMATCH %0t: outputs not idle after finish, x=%h", $time, operand);
                mismatch_count++;
            end
        end
    endtask

    // Second start mid-run must be dropped
    task automatic run_busy_start(input sqrt_fmt_pkg::float_word_t first,
                                  input sqrt_fmt_pkg::float_word_t second);
        int   lat;
        int   n;
        int   extra;
        logic seen;
        launch_op(first);
        repeat (BUSY_GAP) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        x     = second;
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
        wait_finish(lat, seen);
        if (!seen) begin
            $display("Timeout: no finish for operand %h with a start while busy", first);
            timeout_count++;
        end else begin
            // First run keeps its own schedule
            if (lat != LAT_NORMAL - BUSY_GAP - 1) begin
                $display("MISMATCH %0t: finish %0d cycles after ignored start, expected %0d",
                         $time, lat, LAT_NORMAL - BUSY_GAP - 1);
                mismatch_count++;
            end
            if (res !== sqrt_ref(first)) begin
                $display("MISMATCH %0t: res=%h expected first operand result %h",
                         $time, res, sqrt_ref(first));
                mismatch_count++;
            end
        end
        // Fixed watch window for a stray second result
        extra = 0;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (finish || busy) begin
                extra++;
            end
        end
        if (extra != 0) begin
            $display("Start while busy was not ignored, DUT ran a second operation");
            other_count++;
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk            = 1'b0;
        rst_l          = 1'b0;
        start          = 1'b0;
        x              = '0;
        seed           = 90;
        mismatch_count = 0;
        timeout_count  = 0;
        other_count    = 0;
        load_table();

        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        rst_l = 1'b1;

        // Quiet outputs before any start
        repeat (3) begin
            if (finish !== 1'b0 || busy !== 1'b0 || res !== '0) begin
                $display("MISMATCH %0t: outputs not idle after reset", $time);
                mismatch_count++;
            end
            @(posedge clk);
            #DRIVE_DLY;
        end

        for (i = 0; i < NUM_VEC; i++) begin
            ref_word = sqrt_ref(vectors[i].operand);
            if (ref_word !== vectors[i].expected) begin
                $display("MISMATCH %0t: table row %0d hand value %h, reference %h",
                         $time, i, vectors[i].expected, ref_word);
                mismatch_count++;
            end
            run_op(vectors[i].operand, vectors[i].cls, vectors[i].expected);
        end

        run_busy_start(32'h4000_0000, 32'h4180_0000);  // 2.0 then 16.0

        for (i = 0; i < NUM_RANDOM; i++) begin
            rnd_exp  = sqrt_fmt_pkg::exp_t'(1 + ($unsigned($random(seed)) % 254));
            rnd_frac = sqrt_fmt_pkg::frac_t'($random(seed));
            rnd_op   = {1'b0, rnd_exp, rnd_frac};
            run_op(rnd_op, CLS_NORMAL, sqrt_ref(rnd_op));
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count == 0 && timeout_count == 0 && other_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
design/sqrt_alg_pkg.sv
design/sqrt_fmt_pkg.sv
design/sqrt_unpack.sv
design/sqrt_residual.sv
design/sqrt_root_conv.sv
design/sqrt_control.sv
design/fp_sqrt_top.sv
sim/fp_sqrt_props.sv
sim/fp_sqrt_tb.sv
